//--- u1p_ctrl_core.f
verilog/u1p_ctrl_pkg.sv
verilog/wb_slave_decode.sv
verilog/misc_regs.sv
verilog/settings_bus_16.sv
verilog/core_settings.sv
verilog/vita_time_64.sv
verilog/readback_mux_32.sv
verilog/u1p_ctrl_core.sv
bench/tb_u1p_ctrl_core.sv

//--- Bender.yml
package:
  name: u1p_ctrl_core

sources:
  - files:
      - verilog/u1p_ctrl_pkg.sv
      - verilog/wb_slave_decode.sv
      - verilog/misc_regs.sv
      - verilog/settings_bus_16.sv
      - verilog/core_settings.sv
      - verilog/vita_time_64.sv
      - verilog/readback_mux_32.sv
      - verilog/u1p_ctrl_core.sv
  - target: simulation
    files:
      - bench/tb_u1p_ctrl_core.sv

//--- bench/tb_u1p_ctrl_core.sv
//////////////////////////////////////////////////
// testbench for the control-plane core
// one wishbone master, one transfer at a time
// inputs change 1 ns after the rising edge
// stops at the first mismatch or missing ack
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_u1p_ctrl_core;

   import u1p_ctrl_pkg::*;

   localparam int        ACK_TIMEOUT = 16;   // cycles before a missing ack is an error
   localparam int        STB_TIMEOUT = 8;
   localparam int        SLOT_WAIT   = 20;   // no-ack window for an empty slot
   localparam bus_addr_t RDBK_BASE   = {SLAVE_RDBK, 7'd0};

   typedef struct packed
   {
      logic      wr;
      bus_addr_t addr;
      bus_data_t data;
      bus_data_t exp;
   } row_t;

   logic       wb_clk;
   logic       wb_rst;
   bus_addr_t  wb_adr;
   bus_data_t  wb_dat_wr;
   bus_data_t  wb_dat_rd;
   logic       wb_we;
   logic       wb_stb;
   logic       wb_cyc;
   logic       wb_ack;
   logic [2:0] debug_led;
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   logic       cgen_status;
   logic       cgen_ld;
   logic       cgen_refmon;
   logic       pps;
   logic [7:0] frames_per_packet;
   bus_data_t  test_len;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   logic       clear_rx;
   logic       clear_tx;

   row_t        table_q[$];
   logic [31:0] lcg_state      = 32'd61820;
   int          set_stb_count  = 0;
   int          clear_rx_count = 0;
   int          clear_tx_count = 0;
   set_addr_t   last_set_addr;
   set_data_t   last_set_data;

   u1p_ctrl_core i_u1p_ctrl_core
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_wr), .wb_we_i(wb_we),
      .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_dat_o(wb_dat_rd), .wb_ack_o(wb_ack),
      .debug_led_o(debug_led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .cgen_st_status_i(cgen_status), .cgen_st_ld_i(cgen_ld),
      .cgen_st_refmon_i(cgen_refmon), .pps_i(pps),
      .frames_per_packet_o(frames_per_packet), .test_len_o(test_len),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .clear_rx_o(clear_rx), .clear_tx_o(clear_tx));

   initial
   begin
      wb_clk = 1'b0;
      forever
         #4 wb_clk = ~wb_clk;
   end

   // pulse counters sampled mid cycle
   always @(negedge wb_clk)
   begin
      if (set_stb)
      begin
         set_stb_count = set_stb_count + 1;
         last_set_addr = set_addr;
         last_set_data = set_data;
      end
      if (clear_rx)
         clear_rx_count = clear_rx_count + 1;
      if (clear_tx)
         clear_tx_count = clear_tx_count + 1;
   end

   //////////////////////////////////////////////////
   // random data and compare tasks

   function automatic bus_data_t rand16();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];    // upper bits since the low ones cycle fast
   endfunction

   function automatic set_data_t rand32();
      set_data_t hi;
      hi = rand16();
      return {hi, rand16()};
   endfunction

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_bus(input string name, input bus_data_t got, input bus_data_t exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is 0x%04h, expected 0x%04h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input set_data_t got, input set_data_t exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is 0x%016h, expected 0x%016h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////
   // bus tasks entered and left 1 ns after an edge

   task automatic bus_cycle(input logic we, input bus_addr_t addr, input bus_data_t wdata,
                            input int max_cycles, output bus_data_t rdata,
                            output logic acked);
      int n;
      n      = 0;
      acked  = 1'b0;
      rdata  = '0;
      wb_adr    = addr;
      wb_dat_wr = wdata;
      wb_we     = we;
      wb_stb    = 1'b1;
      wb_cyc    = 1'b1;
      while (!acked && n < max_cycles)
      begin
         #2;                        // ack and data settled mid cycle
         if (wb_ack)
         begin
            acked = 1'b1;
            rdata = wb_dat_rd;
         end
         @(posedge wb_clk);
         #1;
         n++;
      end
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input bus_addr_t addr, input bus_data_t data);
      bus_data_t unused;
      logic      acked;
      bus_cycle(1'b1, addr, data, ACK_TIMEOUT, unused, acked);
      if (!acked)
      begin
         $display("bus write to 0x%03h got no ack within %0d cycles", addr, ACK_TIMEOUT);
         abort_run();
      end
   endtask

   task automatic wb_read(input bus_addr_t addr, output bus_data_t data);
      logic acked;
      bus_cycle(1'b0, addr, 16'd0, ACK_TIMEOUT, data, acked);
      if (!acked)
      begin
         $display("bus read from 0x%03h got no ack within %0d cycles", addr, ACK_TIMEOUT);
         abort_run();
      end
   endtask

   task automatic settle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   // low half first and the high half fires the strobe
   task automatic settings_write(input set_addr_t sa, input set_data_t data);
      bus_addr_t addr;
      int        start_count;
      int        n;
      addr        = {SLAVE_SETTINGS[3:1], sa[5:0], 2'b00};
      start_count = set_stb_count;
      n           = 0;
      wb_write(addr, data[15:0]);
      wb_write(addr | 11'd2, data[31:16]);
      while (set_stb_count == start_count && n < STB_TIMEOUT)
      begin
         @(posedge wb_clk);
         #1;
         n++;
      end
      if (set_stb_count == start_count)
      begin
         $display("no set_stb_o pulse within %0d cycles of settings write %0d",
                  STB_TIMEOUT, sa);
         abort_run();
      end
      settle_cycles(2);              // let the one-cycle downstream pulses pass
   endtask

   task automatic read_word(input int idx, output set_data_t word);
      bus_addr_t addr;
      bus_data_t lo_half;
      bus_data_t hi_half;
      addr = RDBK_BASE + 4 * idx;
      wb_read(addr, lo_half);
      wb_read(addr | 11'd2, hi_half);
      word = {hi_half, lo_half};
   endtask

   task automatic add_row(input logic wr, input bus_addr_t addr, input bus_data_t data,
                          input bus_data_t exp);
      table_q.push_back({wr, addr, data, exp});
   endtask

   task automatic apply_table();
      bus_data_t rd;
      row_t      r;
      for (int i = 0; i < table_q.size(); i++)
      begin
         r = table_q[i];
         if (r.wr)
            wb_write(r.addr, r.data);
         else
         begin
            wb_read(r.addr, rd);
            check_bus($sformatf("wb_dat_o at 0x%03h", r.addr), rd, r.exp);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial
   begin
      bus_data_t  rd;
      bus_data_t  led_val;
      bus_data_t  cgen_val;
      bus_data_t  test_val;
      bus_data_t  fpl_val;
      set_data_t  word;
      set_data_t  t32;
      set_data_t  time_hi;
      set_data_t  time_lo;
      logic       acked;
      int         base;
      int         rx_base;
      int         tx_base;
      int         d;

      wb_rst      = 1'b1;
      wb_adr      = '0;
      wb_dat_wr   = '0;
      wb_we       = 1'b0;
      wb_stb      = 1'b0;
      wb_cyc      = 1'b0;
      cgen_status = 1'b0;
      cgen_ld     = 1'b0;
      cgen_refmon = 1'b0;
      pps         = 1'b0;
      for (int i = 0; i < 5; i++)
         @(posedge wb_clk);
      #1 wb_rst = 1'b0;

      // slave 0 reset values then random writes read back
      check_bit("cgen_sync_b_o", cgen_sync_b, 1'b1);
      check_bit("cgen_ref_sel_o", cgen_ref_sel, 1'b1);
      check_bit("set_stb_o", set_stb, 1'b0);
      check_bit("clear_rx_o", clear_rx, 1'b0);
      check_bit("clear_tx_o", clear_tx, 1'b0);
      check_bit("wb_ack_o", wb_ack, 1'b0);
      led_val  = rand16();
      cgen_val = rand16();
      test_val = rand16();
      fpl_val  = rand16();
      add_row(1'b0, {SLAVE_MISC, REG_LEDS}, 16'd0, 16'd0);
      add_row(1'b0, {SLAVE_MISC, REG_CGEN_CTRL}, 16'd0, 16'd3);
      add_row(1'b1, {SLAVE_MISC, REG_LEDS}, led_val, 16'd0);
      add_row(1'b1, {SLAVE_MISC, REG_CGEN_CTRL}, cgen_val, 16'd0);
      add_row(1'b1, {SLAVE_MISC, REG_TEST}, test_val, 16'd0);
      add_row(1'b1, {SLAVE_MISC, REG_RX_FRAMELEN}, fpl_val, 16'd0);
      add_row(1'b0, {SLAVE_MISC, REG_LEDS}, 16'd0, led_val);
      add_row(1'b0, {SLAVE_MISC, REG_CGEN_CTRL}, 16'd0, cgen_val);
      add_row(1'b0, {SLAVE_MISC, REG_TEST}, 16'd0, test_val);
      add_row(1'b0, {SLAVE_MISC, REG_COMPAT}, 16'd0, 16'd5);
      add_row(1'b0, {SLAVE_MISC, 7'd12}, 16'd0, 16'hBEEF);    // unused offset
      apply_table();
      check_bus("debug_led_o", {13'd0, debug_led}, {13'd0, led_val[2], led_val[0], led_val[1]});
      check_bit("cgen_sync_b_o", cgen_sync_b, cgen_val[1]);
      check_bit("cgen_ref_sel_o", cgen_ref_sel, cgen_val[0]);
      check_bus("frames_per_packet_o", {8'd0, frames_per_packet}, {8'd0, fpl_val[7:0]});
      check_bus("test_len_o", test_len, test_val);

      // status bits in order status, ld, refmon
      for (int i = 0; i < 8; i++)
      begin
         {cgen_status, cgen_ld, cgen_refmon} = i[2:0];
         wb_read({SLAVE_MISC, REG_CGEN_ST}, rd);
         check_bus("cgen status read", rd, {13'd0, i[2:0]});
      end

      // settings path and test word readback
      t32  = rand32();
      base = set_stb_count;
      settings_write(SR_REG_TEST32, t32);
      d = set_stb_count - base;
      check_bus("set_stb_o pulse count", d[15:0], 16'd1);
      check_bus("set_addr_o", {8'd0, last_set_addr}, 16'd60);
      check_word("set_data_o", last_set_data, t32);
      read_word(4, word);
      check_word("readback word 4", word, t32);

      // fifo clears with one pulse each
      rx_base = clear_rx_count;
      tx_base = clear_tx_count;
      settings_write(SR_CLEAR_RX_FIFO, rand32());
      d = clear_rx_count - rx_base;
      check_bus("clear_rx_o pulse count", d[15:0], 16'd1);
      d = clear_tx_count - tx_base;
      check_bus("clear_tx_o pulse count", d[15:0], 16'd0);
      settings_write(SR_CLEAR_TX_FIFO, rand32());
      d = clear_rx_count - rx_base;
      check_bus("clear_rx_o pulse count", d[15:0], 16'd1);
      d = clear_tx_count - tx_base;
      check_bus("clear_tx_o pulse count", d[15:0], 16'd1);

      // soft reset brings slave 0 back to reset values
      settings_write(SR_GLOBAL_RESET, rand32());
      wb_read({SLAVE_MISC, REG_LEDS}, rd);
      check_bus("leds after soft reset", rd, 16'd0);
      wb_read({SLAVE_MISC, REG_CGEN_CTRL}, rd);
      check_bus("cgen ctrl after soft reset", rd, 16'd3);
      check_bit("cgen_sync_b_o", cgen_sync_b, 1'b1);
      check_bit("cgen_ref_sel_o", cgen_ref_sel, 1'b1);
      check_bus("test_len_o", test_len, 16'd0);
      check_bus("frames_per_packet_o", {8'd0, frames_per_packet}, 16'd0);

      // time load with the low word well clear of a carry
      time_hi = rand32();
      time_lo = {rand16(), 16'h0100};
      settings_write(SR_TIME64, time_hi);
      settings_write(SR_TIME64 + 8'd1, time_lo);
      read_word(0, word);
      check_time("vita time high word", {word, 32'd0}, {time_hi, 32'd0});
      read_word(1, word);
      check_bit($sformatf("vita time low word 0x%08h in range", word),
                (word >= time_lo) && (word <= time_lo + 200), 1'b1);

      // pps capture through the two-flop sampler
      pps = 1'b1;
      settle_cycles(4);
      pps = 1'b0;
      read_word(2, word);
      check_time("pps time high word", {word, 32'd0}, {time_hi, 32'd0});
      read_word(3, word);
      check_bit($sformatf("pps time low word 0x%08h in range", word),
                (word >= time_lo) && (word <= time_lo + 200), 1'b1);

      // slot 2 has no slave so the read must time out
      bus_cycle(1'b0, {4'd2, 7'd0}, 16'd0, SLOT_WAIT, rd, acked);
      check_bit("wb_ack_o for slot 2", acked, 1'b0);

      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- verilog/u1p_ctrl_core.sv
//////////////////////////////////////////////////
// control plane top, single wishbone master
// slots: 0 misc, 7 readback, 8-9 settings
// other slots never ack
// all logic runs on wb_clk
//////////////////////////////////////////////////

`timescale 1ns/1ns

module u1p_ctrl_core
  (input  logic                    wb_clk,
   input  logic                    wb_rst,

   input  u1p_ctrl_pkg::bus_addr_t wb_adr_i,
   input  u1p_ctrl_pkg::bus_data_t wb_dat_i,
   input  logic                    wb_we_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_cyc_i,
   output u1p_ctrl_pkg::bus_data_t wb_dat_o,
   output logic                    wb_ack_o,

   output logic [2:0]              debug_led_o,
   output logic                    cgen_sync_b_o,
   output logic                    cgen_ref_sel_o,
   input  logic                    cgen_st_status_i,
   input  logic                    cgen_st_ld_i,
   input  logic                    cgen_st_refmon_i,
   input  logic                    pps_i,

   output logic [7:0]              frames_per_packet_o,
   output u1p_ctrl_pkg::bus_data_t test_len_o,

   output logic                    set_stb_o,
   output u1p_ctrl_pkg::set_addr_t set_addr_o,
   output u1p_ctrl_pkg::set_data_t set_data_o,

   output logic                    clear_rx_o,
   output logic                    clear_tx_o);

   import u1p_ctrl_pkg::*;

   logic       core_rst;
   logic       misc_stb;
   logic       rdbk_stb;
   logic       set_bus_stb;
   logic       misc_ack;
   logic       rdbk_ack;
   logic       set_ack;
   bus_data_t  misc_dat;
   bus_data_t  rdbk_dat;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   set_data_t  reg_test32;

   //////////////////////////////////////////////////
   // bus decode

   wb_slave_decode i_wb_slave_decode
     (.wb_adr_i(wb_adr_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .misc_stb_o(misc_stb), .rdbk_stb_o(rdbk_stb), .set_stb_bus_o(set_bus_stb),
      .misc_ack_i(misc_ack), .rdbk_ack_i(rdbk_ack), .set_ack_i(set_ack),
      .misc_dat_i(misc_dat), .rdbk_dat_i(rdbk_dat),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o));

   //////////////////////////////////////////////////
   // slaves

   misc_regs i_misc_regs
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i[6:0]),
      .dat_i(wb_dat_i), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .debug_led_o(debug_led_o), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o),
      .frames_per_packet_o(frames_per_packet_o), .test_len_o(test_len_o));

   settings_bus_16 i_settings_bus_16
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .stb_i(set_bus_stb), .we_i(wb_we_i), .adr_i(wb_adr_i),
      .dat_i(wb_dat_i), .ack_o(set_ack),
      .set_stb_o(set_stb_o), .set_addr_o(set_addr_o), .set_data_o(set_data_o));

   core_settings i_core_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_o), .set_addr_i(set_addr_o), .set_data_i(set_data_o),
      .reg_test32_o(reg_test32), .clear_rx_o(clear_rx_o), .clear_tx_o(clear_tx_o),
      .core_rst_o(core_rst));

   vita_time_64 i_vita_time_64
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .set_stb_i(set_stb_o), .set_addr_i(set_addr_o), .set_data_i(set_data_o),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   readback_mux_32 i_readback_mux_32
     (.wb_clk(wb_clk), .core_rst_i(core_rst),
      .stb_i(rdbk_stb), .adr_i(wb_adr_i[6:0]), .dat_o(rdbk_dat), .ack_o(rdbk_ack),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .reg_test32_i(reg_test32));

endmodule

//--- verilog/readback_mux_32.sv
//////////////////////////////////////////////////
// slave 7 returns 32-bit readback words as two
// 16-bit halves where adr[1]=0 selects the low half
// one wait state so each read takes two cycles
//////////////////////////////////////////////////

`timescale 1ns/1ns

module readback_mux_32
  (input  logic                     wb_clk,
   input  logic                     core_rst_i,

   input  logic                     stb_i,
   input  logic [6:0]               adr_i,
   output u1p_ctrl_pkg::bus_data_t  dat_o,
   output logic                     ack_o,

   input  u1p_ctrl_pkg::vita_time_t vita_time_i,
   input  u1p_ctrl_pkg::vita_time_t vita_time_pps_i,
   input  u1p_ctrl_pkg::set_data_t  reg_test32_i);

   import u1p_ctrl_pkg::*;

   logic [$clog2(RDBK_WORDS)-1:0] word_idx;
   set_data_t                     word_sel;

   assign word_idx = adr_i[5:2];

   always_comb
   begin
      case (word_idx)
         4'd0:    word_sel = vita_time_i[63:32];
         4'd1:    word_sel = vita_time_i[31:0];
         4'd2:    word_sel = vita_time_pps_i[63:32];
         4'd3:    word_sel = vita_time_pps_i[31:0];
         4'd4:    word_sel = reg_test32_i;
         default: word_sel = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i[1] ? word_sel[31:16] : word_sel[15:0];
   end

   // ack drops after one cycle even if stb is still up
   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   // the master must hold stb until the registered ack arrives
   assert property (@(posedge wb_clk) disable iff (core_rst_i) (stb_i && !ack_o) |=> stb_i)
      else $error("readback stb dropped before ack");

endmodule

//--- verilog/vita_time_64.sv
//////////////////////////////////////////////////
// 64-bit vita time, one tick per wb_clk
// load high word at SR_TIME64, then the low word
// at SR_TIME64+1 which commits both
// pps_i is asynchronous, sampled by two flops
//////////////////////////////////////////////////

`timescale 1ns/1ns

module vita_time_64
  (input  logic                     wb_clk,
   input  logic                     core_rst_i,

   input  logic                     set_stb_i,
   input  u1p_ctrl_pkg::set_addr_t  set_addr_i,
   input  u1p_ctrl_pkg::set_data_t  set_data_i,

   input  logic                     pps_i,

   output u1p_ctrl_pkg::vita_time_t vita_time_o,
   output u1p_ctrl_pkg::vita_time_t vita_time_pps_o);

   import u1p_ctrl_pkg::*;

   set_data_t  time_hi_pend;    // high word waiting for the low word
   logic [1:0] pps_sync;
   logic       pps_rise;

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SR_TIME64))
         time_hi_pend <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         vita_time_o <= '0;
      else if (set_stb_i && (set_addr_i == SR_TIME64 + 8'd1))
         vita_time_o <= {time_hi_pend, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   //////////////////////////////////////////////////
   // pps capture

   assign pps_rise = pps_sync[0] & ~pps_sync[1];

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         pps_sync        <= 2'b00;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         if (pps_rise)
            vita_time_pps_o <= vita_time_o;   // snapshot at the edge
      end
   end

endmodule

//--- verilog/core_settings.sv
//////////////////////////////////////////////////
// settings-mapped registers of the core
// clear and soft reset are one-cycle pulses
// core_rst_o is wb_rst or'd with the soft reset,
// both in the wb_clk domain
//////////////////////////////////////////////////

`timescale 1ns/1ns

module core_settings
  (input  logic                    wb_clk,
   input  logic                    wb_rst,

   input  logic                    set_stb_i,
   input  u1p_ctrl_pkg::set_addr_t set_addr_i,
   input  u1p_ctrl_pkg::set_data_t set_data_i,

   output u1p_ctrl_pkg::set_data_t reg_test32_o,
   output logic                    clear_rx_o,
   output logic                    clear_tx_o,
   output logic                    core_rst_o);

   import u1p_ctrl_pkg::*;

   logic hit_test32;
   logic hit_clr_rx;
   logic hit_clr_tx;
   logic hit_reset;
   logic soft_rst;

   // address match, qualified by the strobe
   assign hit_test32 = set_stb_i & (set_addr_i == SR_REG_TEST32);
   assign hit_clr_rx = set_stb_i & (set_addr_i == SR_CLEAR_RX_FIFO);
   assign hit_clr_tx = set_stb_i & (set_addr_i == SR_CLEAR_TX_FIFO);
   assign hit_reset  = set_stb_i & (set_addr_i == SR_GLOBAL_RESET);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_test32_o <= '0;
         clear_rx_o   <= 1'b0;
         clear_tx_o   <= 1'b0;
         soft_rst     <= 1'b0;
      end
      else
      begin
         if (hit_test32)
            reg_test32_o <= set_data_i;
         clear_rx_o <= hit_clr_rx;     // data value is ignored
         clear_tx_o <= hit_clr_tx;
         soft_rst   <= hit_reset;
      end
   end

   assign core_rst_o = wb_rst | soft_rst;

endmodule

//--- verilog/settings_bus_16.sv
//////////////////////////////////////////////////
// 16-bit bus to 32-bit settings writes
// write the low half (adr[1]=0) first, the high
// half (adr[1]=1) then fires the strobe
// register address is adr[7:2], 64 registers
//////////////////////////////////////////////////

`timescale 1ns/1ns

module settings_bus_16
  (input  logic                    wb_clk,
   input  logic                    core_rst_i,

   input  logic                    stb_i,
   input  logic                    we_i,
   input  u1p_ctrl_pkg::bus_addr_t adr_i,
   input  u1p_ctrl_pkg::bus_data_t dat_i,
   output logic                    ack_o,

   output logic                    set_stb_o,
   output u1p_ctrl_pkg::set_addr_t set_addr_o,
   output u1p_ctrl_pkg::set_data_t set_data_o);

   import u1p_ctrl_pkg::*;

   bus_data_t low_half;
   logic      wr_lo;
   logic      wr_hi;

   assign wr_lo = stb_i & we_i & ~adr_i[1];
   assign wr_hi = stb_i & we_i & adr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         low_half <= dat_i;
      if (wr_hi)
      begin
         set_data_o <= {dat_i, low_half};
         set_addr_o <= {2'b00, adr_i[7:2]};
      end
   end

   // strobe lands on the clock after the high half
   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_hi;
   end

   assign ack_o = stb_i;

   // a full settings write needs two bus cycles, so strobes never touch
   assert property (@(posedge wb_clk) disable iff (core_rst_i) set_stb_o |=> !set_stb_o)
      else $error("set_stb_o high for two cycles");

endmodule

//--- verilog/misc_regs.sv
//////////////////////////////////////////////////
// slave 0, board control and status registers
// single-cycle slave, ack follows stb directly
// led pins are wired out of order on the board
//////////////////////////////////////////////////

`timescale 1ns/1ns

module misc_regs
  (input  logic                    wb_clk,
   input  logic                    core_rst_i,

   input  logic                    stb_i,
   input  logic                    we_i,
   input  logic [6:0]              adr_i,
   input  u1p_ctrl_pkg::bus_data_t dat_i,
   output u1p_ctrl_pkg::bus_data_t dat_o,
   output logic                    ack_o,

   input  logic                    cgen_st_status_i,
   input  logic                    cgen_st_ld_i,
   input  logic                    cgen_st_refmon_i,

   output logic [2:0]              debug_led_o,
   output logic                    cgen_sync_b_o,
   output logic                    cgen_ref_sel_o,
   output logic [7:0]              frames_per_packet_o,
   output u1p_ctrl_pkg::bus_data_t test_len_o);

   import u1p_ctrl_pkg::*;

   bus_data_t reg_leds;
   bus_data_t reg_cgen_ctrl;
   bus_data_t reg_test;

   //////////////////////////////////////////////////
   // write side

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         reg_leds            <= '0;
         reg_cgen_ctrl       <= CGEN_CTRL_RESET;
         reg_test            <= '0;
         frames_per_packet_o <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i)
            REG_LEDS:        reg_leds            <= dat_i;
            REG_CGEN_CTRL:   reg_cgen_ctrl       <= dat_i;
            REG_TEST:        reg_test            <= dat_i;
            REG_RX_FRAMELEN: frames_per_packet_o <= dat_i[7:0];
            default:         ;
         endcase
      end
   end

   assign {debug_led_o[2], debug_led_o[0], debug_led_o[1]} = reg_leds[2:0];  // board order
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];
   assign test_len_o = reg_test;

   //////////////////////////////////////////////////
   // read side

   always_comb
   begin
      case (adr_i)
         REG_LEDS:      dat_o = reg_leds;
         REG_CGEN_CTRL: dat_o = reg_cgen_ctrl;
         REG_CGEN_ST:   dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      dat_o = reg_test;
         REG_COMPAT:    dat_o = {8'd0, COMPAT_NUM};
         default:       dat_o = MISC_DEFAULT_RD;
      endcase
   end

   assign ack_o = stb_i;   // no wait states

endmodule

//--- verilog/wb_slave_decode.sv
//////////////////////////////////////////////////
// single-master address decode on adr[10:7]
// unmapped slots are never acked, so the master
// must time out on them
// settings slots return zero on reads
//////////////////////////////////////////////////

`timescale 1ns/1ns

module wb_slave_decode
  (input  u1p_ctrl_pkg::bus_addr_t wb_adr_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_cyc_i,

   output logic                    misc_stb_o,
   output logic                    rdbk_stb_o,
   output logic                    set_stb_bus_o,

   input  logic                    misc_ack_i,
   input  logic                    rdbk_ack_i,
   input  logic                    set_ack_i,
   input  u1p_ctrl_pkg::bus_data_t misc_dat_i,
   input  u1p_ctrl_pkg::bus_data_t rdbk_dat_i,

   output logic                    wb_ack_o,
   output u1p_ctrl_pkg::bus_data_t wb_dat_o);

   import u1p_ctrl_pkg::*;

   logic       bus_req;
   logic [3:0] slot;

   assign bus_req = wb_stb_i & wb_cyc_i;
   assign slot    = wb_adr_i[10:7];

   // strobes to the slaves
   assign misc_stb_o    = bus_req & (slot == SLAVE_MISC);
   assign rdbk_stb_o    = bus_req & (slot == SLAVE_RDBK);
   assign set_stb_bus_o = bus_req & (slot[3:1] == SLAVE_SETTINGS[3:1]);  // double-wide slot

   // only the addressed slave may complete the cycle
   assign wb_ack_o = (misc_stb_o & misc_ack_i) |
                     (rdbk_stb_o & rdbk_ack_i) |
                     (set_stb_bus_o & set_ack_i);

   always_comb
   begin
      if (slot == SLAVE_MISC)
         wb_dat_o = misc_dat_i;
      else if (slot == SLAVE_RDBK)
         wb_dat_o = rdbk_dat_i;
      else
         wb_dat_o = '0;    // settings and empty slots
   end

   // two slaves must never ack in the same cycle
   assert final ($onehot0({misc_ack_i, rdbk_ack_i, set_ack_i}))
      else $error("more than one slave acked");

endmodule

//--- verilog/u1p_ctrl_pkg.sv
//////////////////////////////////////////////////
// shared widths, settings addresses and slave-0
// offsets for the control-plane core
// bus is 16 bits wide with an 11-bit byte address
// settings registers are 32 bits, 64 of them
//////////////////////////////////////////////////

package u1p_ctrl_pkg;

   //////////////////////////////////////////////////
   // widths that carry a meaning

   typedef logic [10:0] bus_addr_t;   // wishbone byte address
   typedef logic [15:0] bus_data_t;   // wishbone data word
   typedef logic [7:0]  set_addr_t;   // settings register address
   typedef logic [31:0] set_data_t;   // settings data
   typedef logic [63:0] vita_time_t;  // vita time, ticks

   //////////////////////////////////////////////////
   // slave slots on adr[10:7]

   localparam logic [3:0] SLAVE_MISC     = 4'd0;
   localparam logic [3:0] SLAVE_RDBK     = 4'd7;
   localparam logic [3:0] SLAVE_SETTINGS = 4'd8;  // matched on [3:1], covers 8 and 9

   //////////////////////////////////////////////////
   // settings bus addresses

   localparam set_addr_t SR_TIME64        = 8'd42;  // +0 high word, +1 low word
   localparam set_addr_t SR_REG_TEST32    = 8'd60;
   localparam set_addr_t SR_CLEAR_RX_FIFO = 8'd61;
   localparam set_addr_t SR_CLEAR_TX_FIFO = 8'd62;
   localparam set_addr_t SR_GLOBAL_RESET  = 8'd63;

   //////////////////////////////////////////////////
   // slave 0 register offsets on adr[6:0]

   localparam logic [6:0] REG_LEDS        = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL   = 7'd4;
   localparam logic [6:0] REG_CGEN_ST     = 7'd6;   // read only
   localparam logic [6:0] REG_TEST        = 7'd8;
   localparam logic [6:0] REG_RX_FRAMELEN = 7'd10;  // write only
   localparam logic [6:0] REG_COMPAT      = 7'd16;  // read only

   //////////////////////////////////////////////////
   // constants

   localparam logic [7:0] COMPAT_NUM      = 8'd5;
   localparam bus_data_t  CGEN_CTRL_RESET = 16'd3;      // sync_b and ref_sel high
   localparam bus_data_t  MISC_DEFAULT_RD = 16'hBEEF;   // unused slave-0 offsets

   localparam int RDBK_WORDS = 16;  // 32-bit words behind slave 7

endpackage
